/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire mips_exec_pkg::alu_ctrl_e            i_alu_ctrl,
   input  wire logic [mips_exec_pkg::DATA_W-1:0]    i_data_a,
   input  wire logic [mips_exec_pkg::DATA_W-1:0]    i_data_b,
   output logic [mips_exec_pkg::DATA_W-1:0]         o_result
);

   import mips_exec_pkg::*;

   logic [SHAMT_W-1:0] shift_amt;
   logic               less_than;

   assign shift_amt = i_data_b[SHAMT_W-1:0];                // Low 5 bits only
   assign less_than = $signed(i_data_a) < $signed(i_data_b);

   always_comb
   begin
      case (i_alu_ctrl)
         ALU_AND:   o_result = i_data_a & i_data_b;         // AND, ANDI
         ALU_OR:    o_result = i_data_a | i_data_b;         // OR, ORI
         ALU_XOR:   o_result = i_data_a ^ i_data_b;         // XOR, XORI
         ALU_NOR:   o_result = ~(i_data_a | i_data_b);
         ALU_ADD:   o_result = i_data_a + i_data_b;         // ADDU, ADDI, LW, SW
         ALU_SUB:   o_result = i_data_a - i_data_b;
         ALU_SLT:   o_result = {{(DATA_W-1){1'b0}}, less_than};
         ALU_LUI:   o_result = i_data_b << 16;              // Immediate to upper half
         ALU_SLL:   o_result = i_data_a << shift_amt;       // SLL, SLLV
         ALU_SRL:   o_result = i_data_a >> shift_amt;       // SRL, SRLV
         ALU_SRA:   o_result = $unsigned($signed(i_data_a) >>> shift_amt);
         ALU_PASSA: o_result = i_data_a;                    // JR target
         default:   o_result = i_data_a + i_data_b;
      endcase
   end

   // The control code comes straight from the ID/EX register,
   // so an unknown here means the decode stage lost its reset
   always_comb
   begin
      a_ctrl_known: assert final (!$isunknown(i_alu_ctrl));
   end

endmodule

`default_nettype wire

/* design/alu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_control (
   input  wire logic [5:0]             i_opcode,
   input  wire logic [5:0]             i_funct,
   output mips_exec_pkg::alu_ctrl_e    o_alu_ctrl,
   output logic                        o_imm_sel,
   output logic                        o_sign_ext,
   output logic                        o_src_a_shift,
   output logic                        o_shamt_sel,
   output logic                        o_reg_write,
   output logic                        o_illegal
);

   import mips_exec_pkg::*;

   always_comb
   begin
      o_alu_ctrl    = ALU_ADD;                   // Safe default
      o_imm_sel     = 1'b0;
      o_sign_ext    = 1'b1;
      o_src_a_shift = 1'b0;
      o_shamt_sel   = 1'b0;
      o_reg_write   = 1'b0;
      o_illegal     = 1'b0;

      if (i_opcode == OP_RTYPE)
      begin
         o_reg_write = 1'b1;
         case (i_funct)
            FN_SLL:  begin o_alu_ctrl = ALU_SLL; o_src_a_shift = 1'b1; o_shamt_sel = 1'b1; end
            FN_SRL:  begin o_alu_ctrl = ALU_SRL; o_src_a_shift = 1'b1; o_shamt_sel = 1'b1; end
            FN_SRA:  begin o_alu_ctrl = ALU_SRA; o_src_a_shift = 1'b1; o_shamt_sel = 1'b1; end
            FN_SLLV: begin o_alu_ctrl = ALU_SLL; o_src_a_shift = 1'b1; end
            FN_SRLV: begin o_alu_ctrl = ALU_SRL; o_src_a_shift = 1'b1; end
            FN_SRAV: begin o_alu_ctrl = ALU_SRA; o_src_a_shift = 1'b1; end
            FN_JR:   begin o_alu_ctrl = ALU_PASSA; o_reg_write = 1'b0; end
            FN_ADDU: o_alu_ctrl = ALU_ADD;
            FN_SUBU: o_alu_ctrl = ALU_SUB;
            FN_AND:  o_alu_ctrl = ALU_AND;
            FN_OR:   o_alu_ctrl = ALU_OR;
            FN_XOR:  o_alu_ctrl = ALU_XOR;
            FN_NOR:  o_alu_ctrl = ALU_NOR;
            FN_SLT:  o_alu_ctrl = ALU_SLT;
            default: begin o_reg_write = 1'b0; o_illegal = 1'b1; end
         endcase
      end
      else
      begin
         o_imm_sel   = 1'b1;                     // All I-type use the immediate
         o_reg_write = 1'b1;
         case (i_opcode)
            OP_ADDI, OP_ADDIU: o_alu_ctrl = ALU_ADD;   // No overflow trap
            OP_SLTI:           o_alu_ctrl = ALU_SLT;
            OP_ANDI:           begin o_alu_ctrl = ALU_AND; o_sign_ext = 1'b0; end
            OP_ORI:            begin o_alu_ctrl = ALU_OR;  o_sign_ext = 1'b0; end
            OP_XORI:           begin o_alu_ctrl = ALU_XOR; o_sign_ext = 1'b0; end
            OP_LUI:            begin o_alu_ctrl = ALU_LUI; o_sign_ext = 1'b0; end
            OP_LW:             o_alu_ctrl = ALU_ADD;   // Address calc
            OP_SW:             o_reg_write = 1'b0;     // Address calc, no write
            default:
            begin
               o_imm_sel   = 1'b0;
               o_reg_write = 1'b0;
               o_illegal   = 1'b1;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  wire logic                    i_clock,
   input  wire logic                    i_rst_n,
   input  wire mips_exec_pkg::id_ex_t   i_id_ex,
   output mips_exec_pkg::ex_mem_t       o_ex_mem
);

   import mips_exec_pkg::*;

   logic [DATA_W-1:0] data_a;
   logic [DATA_W-1:0] data_b;
   logic [DATA_W-1:0] alu_result;

   ////////////////////////////////////////////////////////////////////
   // Operand select
   ////////////////////////////////////////////////////////////////////
   assign data_a = i_id_ex.src_a_shift ? i_id_ex.rt_val : i_id_ex.rs_val;

   always_comb
   begin
      if (i_id_ex.src_a_shift && i_id_ex.shamt_sel)
         data_b = {{(DATA_W-SHAMT_W){1'b0}}, i_id_ex.shamt};          // SLL, SRL, SRA
      else if (i_id_ex.src_a_shift)
         data_b = {{(DATA_W-SHAMT_W){1'b0}}, i_id_ex.rs_val[SHAMT_W-1:0]};  // Variable
      else if (i_id_ex.imm_sel)
         data_b = i_id_ex.imm_ext;
      else
         data_b = i_id_ex.rt_val;
   end

   alu u_alu (
      .i_alu_ctrl (i_id_ex.alu_ctrl),
      .i_data_a   (data_a),
      .i_data_b   (data_b),
      .o_result   (alu_result)
   );

   // EX/MEM register
   always_ff @(posedge i_clock or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         o_ex_mem <= '0;
      end
      else
      begin
         o_ex_mem.valid      <= i_id_ex.valid;
         o_ex_mem.reg_write  <= i_id_ex.reg_write;      // Already gated in decode
         o_ex_mem.dest       <= i_id_ex.dest;
         o_ex_mem.result     <= alu_result;
         o_ex_mem.store_data <= i_id_ex.rt_val;         // SW data
      end
   end

   a_shift_amt_range: assert property (
      @(posedge i_clock) disable iff (!i_rst_n)
      (i_id_ex.valid && (i_id_ex.alu_ctrl inside {ALU_SLL, ALU_SRL, ALU_SRA}))
         |-> (data_b < DATA_W)
   );

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
   input  wire logic                                i_clock,
   input  wire logic                                i_rst_n,
   input  wire logic                                i_valid,
   input  wire mips_exec_pkg::instr_u               i_instr,
   input  wire logic [mips_exec_pkg::DATA_W-1:0]    i_rs_val,
   input  wire logic [mips_exec_pkg::DATA_W-1:0]    i_rt_val,
   output mips_exec_pkg::id_ex_t                    o_id_ex
);

   import mips_exec_pkg::*;

   alu_ctrl_e         alu_ctrl;
   logic              imm_sel;
   logic              sign_ext;
   logic              src_a_shift;
   logic              shamt_sel;
   logic              ctrl_write;
   logic              illegal;
   logic [REG_W-1:0]  dest;
   logic [DATA_W-1:0] imm_ext;
   logic              reg_write;
   id_ex_t            id_ex_next;

   alu_control u_alu_control (
      .i_opcode      (i_instr.rfmt.opcode),
      .i_funct       (i_instr.rfmt.funct),
      .o_alu_ctrl    (alu_ctrl),
      .o_imm_sel     (imm_sel),
      .o_sign_ext    (sign_ext),
      .o_src_a_shift (src_a_shift),
      .o_shamt_sel   (shamt_sel),
      .o_reg_write   (ctrl_write),
      .o_illegal     (illegal)
   );

   ////////////////////////////////////////////////////////////////////
   // Field extraction
   ////////////////////////////////////////////////////////////////////
   assign dest = (i_instr.rfmt.opcode == OP_RTYPE) ? i_instr.rfmt.rd   // rd for R-type
                                                   : i_instr.ifmt.rt;  // rt for I-type

   assign imm_ext = sign_ext ? {{(DATA_W-IMM_W){i_instr.ifmt.imm[IMM_W-1]}}, i_instr.ifmt.imm}
                             : {{(DATA_W-IMM_W){1'b0}}, i_instr.ifmt.imm};

   // $zero is never written
   assign reg_write = i_valid && ctrl_write && (dest != '0);

   always_comb
   begin
      id_ex_next             = '0;
      id_ex_next.valid       = i_valid;
      id_ex_next.alu_ctrl    = alu_ctrl;
      id_ex_next.reg_write   = reg_write;
      id_ex_next.src_a_shift = src_a_shift;
      id_ex_next.shamt_sel   = shamt_sel;
      id_ex_next.imm_sel     = imm_sel;
      id_ex_next.dest        = dest;
      id_ex_next.rs_val      = i_rs_val;
      id_ex_next.rt_val      = i_rt_val;
      id_ex_next.imm_ext     = imm_ext;
      id_ex_next.shamt       = i_instr.rfmt.shamt;
   end

   ////////////////////////////////////////////////////////////////////
   // ID/EX register
   ////////////////////////////////////////////////////////////////////
   always_ff @(posedge i_clock or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         o_id_ex <= '0;
      end
      else
      begin
         o_id_ex <= id_ex_next;
      end
   end

   // Illegal words leave as harmless records
   a_illegal_no_write: assert property (
      @(posedge i_clock) disable iff (!i_rst_n)
      (i_valid && illegal) |=> !o_id_ex.reg_write
   );

endmodule

`default_nettype wire

/* design/mips_exec_pkg.sv */
`default_nettype none

package mips_exec_pkg;

   ////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////
   localparam int DATA_W  = 32;                  // Data word
   localparam int REG_W   = 5;                   // Register index
   localparam int OP_W    = 6;                   // Major opcode
   localparam int FN_W    = 6;                   // R-type funct
   localparam int SHAMT_W = 5;                   // Shift amount
   localparam int IMM_W   = 16;                  // I-type immediate

   ////////////////////////////////////////////////////////////////////
   // Opcode and funct codes
   ////////////////////////////////////////////////////////////////////
   localparam logic [OP_W-1:0] OP_RTYPE = 6'b000000;
   localparam logic [OP_W-1:0] OP_ADDI  = 6'b001000;
   localparam logic [OP_W-1:0] OP_ADDIU = 6'b001001;
   localparam logic [OP_W-1:0] OP_SLTI  = 6'b001010;
   localparam logic [OP_W-1:0] OP_ANDI  = 6'b001100;
   localparam logic [OP_W-1:0] OP_ORI   = 6'b001101;
   localparam logic [OP_W-1:0] OP_XORI  = 6'b001110;
   localparam logic [OP_W-1:0] OP_LUI   = 6'b001111;
   localparam logic [OP_W-1:0] OP_LW    = 6'b100011;
   localparam logic [OP_W-1:0] OP_SW    = 6'b101011;

   localparam logic [FN_W-1:0] FN_SLL  = 6'b000000;
   localparam logic [FN_W-1:0] FN_SRL  = 6'b000010;
   localparam logic [FN_W-1:0] FN_SRA  = 6'b000011;
   localparam logic [FN_W-1:0] FN_SLLV = 6'b000100;
   localparam logic [FN_W-1:0] FN_SRLV = 6'b000110;
   localparam logic [FN_W-1:0] FN_SRAV = 6'b000111;
   localparam logic [FN_W-1:0] FN_JR   = 6'b001000;
   localparam logic [FN_W-1:0] FN_ADDU = 6'b100001;
   localparam logic [FN_W-1:0] FN_SUBU = 6'b100011;
   localparam logic [FN_W-1:0] FN_AND  = 6'b100100;
   localparam logic [FN_W-1:0] FN_OR   = 6'b100101;
   localparam logic [FN_W-1:0] FN_XOR  = 6'b100110;
   localparam logic [FN_W-1:0] FN_NOR  = 6'b100111;
   localparam logic [FN_W-1:0] FN_SLT  = 6'b101010;

   // ALU control codes
   typedef enum logic [3:0] {
      ALU_AND   = 4'b0000,
      ALU_OR    = 4'b0001,
      ALU_ADD   = 4'b0010,
      ALU_SUB   = 4'b0110,
      ALU_SLT   = 4'b0111,
      ALU_LUI   = 4'b1000,
      ALU_XOR   = 4'b1001,
      ALU_NOR   = 4'b1010,
      ALU_SLL   = 4'b1011,
      ALU_SRL   = 4'b1100,
      ALU_SRA   = 4'b1101,
      ALU_PASSA = 4'b1110                        // Jump target
   } alu_ctrl_e;

   ////////////////////////////////////////////////////////////////////
   // Instruction word views
   ////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [OP_W-1:0]    opcode;
      logic [REG_W-1:0]   rs;
      logic [REG_W-1:0]   rt;
      logic [REG_W-1:0]   rd;
      logic [SHAMT_W-1:0] shamt;
      logic [FN_W-1:0]    funct;
   } r_fields_t;

   typedef struct packed {
      logic [OP_W-1:0]  opcode;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rt;
      logic [IMM_W-1:0] imm;
   } i_fields_t;

   typedef union packed {
      r_fields_t rfmt;
      i_fields_t ifmt;
   } instr_u;

   // Stage records
   typedef struct packed {
      logic               valid;
      alu_ctrl_e          alu_ctrl;
      logic               reg_write;
      logic               src_a_shift;       // A is rt
      logic               shamt_sel;         // Amount from shamt field
      logic               imm_sel;           // B is immediate
      logic [REG_W-1:0]   dest;
      logic [DATA_W-1:0]  rs_val;
      logic [DATA_W-1:0]  rt_val;
      logic [DATA_W-1:0]  imm_ext;
      logic [SHAMT_W-1:0] shamt;
   } id_ex_t;

   typedef struct packed {
      logic              valid;
      logic              reg_write;
      logic [REG_W-1:0]  dest;
      logic [DATA_W-1:0] result;
      logic [DATA_W-1:0] store_data;         // rt value for SW
   } ex_mem_t;

endpackage

`default_nettype wire

/* design/mips_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top (
   input  wire logic                                i_clock,
   input  wire logic                                i_rst_n,
   input  wire logic                                i_valid,
   input  wire mips_exec_pkg::instr_u               i_instr,
   input  wire logic [mips_exec_pkg::DATA_W-1:0]    i_rs_val,
   input  wire logic [mips_exec_pkg::DATA_W-1:0]    i_rt_val,
   output mips_exec_pkg::ex_mem_t                   o_ex_mem
);

   import mips_exec_pkg::*;

   id_ex_t id_ex;                                    // Decode to execute

   instr_decode u_instr_decode (
      .i_clock  (i_clock),
      .i_rst_n  (i_rst_n),
      .i_valid  (i_valid),
      .i_instr  (i_instr),
      .i_rs_val (i_rs_val),
      .i_rt_val (i_rt_val),
      .o_id_ex  (id_ex)
   );

   execute_stage u_execute_stage (
      .i_clock  (i_clock),
      .i_rst_n  (i_rst_n),
      .i_id_ex  (id_ex),
      .o_ex_mem (o_ex_mem)
   );

endmodule

`default_nettype wire

/* filelist.f */
design/mips_exec_pkg.sv
design/alu_control.sv
design/alu.sv
design/instr_decode.sv
design/execute_stage.sv
design/mips_exec_top.sv
verif/tb_mips_exec.sv

/* verif/tb_mips_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec;

   import mips_exec_pkg::*;

   typedef struct packed {
      logic              bubble;             // Drive i_valid low
      logic [DATA_W-1:0] word;
      logic [DATA_W-1:0] rs_val;
      logic [DATA_W-1:0] rt_val;
   } row_t;

   typedef struct packed {
      int      row;
      int      due;                          // Negedge count when checked
      ex_mem_t rec;
      logic    full;                         // Compare the whole record
   } exp_t;

   logic              clock;
   logic              rst_n;
   logic              valid;
   instr_u            instr;
   logic [DATA_W-1:0] rs_val;
   logic [DATA_W-1:0] rt_val;
   ex_mem_t           ex_mem;

   row_t        rows[$];
   string       names[$];
   exp_t        exp_q[$];
   logic [31:0] lfsr_state  = 32'h0f5c026d;
   int          neg_count   = 0;
   int          pass_count  = 0;
   int          fail_count  = 0;
   logic        table_ready = 1'b0;

   mips_exec_top uut (
      .i_clock  (clock),
      .i_rst_n  (rst_n),
      .i_valid  (valid),
      .i_instr  (instr),
      .i_rs_val (rs_val),
      .i_rt_val (rt_val),
      .o_ex_mem (ex_mem)
   );

   initial
   begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   ////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] shamt);
      return {OP_RTYPE, rs, rt, rd, shamt, funct};
   endfunction

   function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic add_row(input string name, input logic bubble, input logic [31:0] word,
                          input logic rnd, input logic [31:0] rs_fix,
                          input logic [31:0] rt_fix);
      row_t r;
      r.bubble = bubble;
      r.word   = word;
      r.rs_val = rs_fix;
      r.rt_val = rt_fix;
      if (rnd)
      begin
         draw_bits(DATA_W, r.rs_val);
         draw_bits(DATA_W, r.rt_val);
      end
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic build_table();
      add_row("addu",    0, enc_r(FN_ADDU, 1, 2, 3, 0), 1, 0, 0);
      add_row("subu",    0, enc_r(FN_SUBU, 4, 5, 6, 0), 1, 0, 0);
      add_row("and",     0, enc_r(FN_AND, 1, 2, 7, 0), 1, 0, 0);
      add_row("or",      0, enc_r(FN_OR, 1, 2, 8, 0), 1, 0, 0);
      add_row("xor",     0, enc_r(FN_XOR, 1, 2, 9, 0), 1, 0, 0);
      add_row("nor",     0, enc_r(FN_NOR, 1, 2, 10, 0), 1, 0, 0);
      add_row("slt",     0, enc_r(FN_SLT, 1, 2, 11, 0), 1, 0, 0);
      add_row("slt_neg", 0, enc_r(FN_SLT, 1, 2, 12, 0), 0, 32'hffff_fffb, 32'h3);
      add_row("slt_pos", 0, enc_r(FN_SLT, 1, 2, 12, 0), 0, 32'h3, 32'hffff_fffb);
      add_row("sll",     0, enc_r(FN_SLL, 0, 2, 13, 4), 1, 0, 0);
      add_row("srl",     0, enc_r(FN_SRL, 0, 2, 14, 17), 1, 0, 0);
      add_row("sra",     0, enc_r(FN_SRA, 0, 2, 15, 8), 0, 32'h1, 32'h8000_1234);
      add_row("sllv",    0, enc_r(FN_SLLV, 1, 2, 16, 0), 1, 0, 0);
      add_row("srav",    0, enc_r(FN_SRAV, 1, 2, 17, 0), 0, 32'hffff_ffe3, 32'hf000_0000);
      add_row("bubble",  1, enc_r(FN_ADDU, 1, 2, 3, 0), 1, 0, 0);
      add_row("srlv",    0, enc_r(FN_SRLV, 1, 2, 18, 0), 1, 0, 0);
      add_row("addi",    0, enc_i(OP_ADDI, 1, 19, 16'hfff0), 1, 0, 0);
      add_row("addiu",   0, enc_i(OP_ADDIU, 1, 20, 16'h8001), 1, 0, 0);
      add_row("slti",    0, enc_i(OP_SLTI, 1, 21, 16'hffff), 0, 32'hffff_fffe, 32'h5);
      add_row("andi",    0, enc_i(OP_ANDI, 1, 22, 16'hf0f0), 1, 0, 0);
      add_row("ori",     0, enc_i(OP_ORI, 1, 23, 16'h8000), 1, 0, 0);
      add_row("xori",    0, enc_i(OP_XORI, 1, 24, 16'hffff), 1, 0, 0);
      add_row("lui",     0, enc_i(OP_LUI, 0, 25, 16'hbeef), 1, 0, 0);
      add_row("lw",      0, enc_i(OP_LW, 1, 26, 16'hfffc), 1, 0, 0);
      add_row("sw",      0, enc_i(OP_SW, 1, 27, 16'h0010), 1, 0, 0);
      add_row("jr",      0, enc_r(FN_JR, 4, 0, 0, 0), 1, 0, 0);
      add_row("addu_r0", 0, enc_r(FN_ADDU, 1, 2, 0, 0), 1, 0, 0);
      add_row("bad_op",  0, enc_i(6'b111111, 1, 2, 16'h1234), 1, 0, 0);
      add_row("bad_fn",  0, enc_r(6'b111111, 1, 2, 3, 0), 1, 0, 0);
      add_row("bubble2", 1, enc_i(OP_LW, 1, 2, 16'h0004), 1, 0, 0);
   endtask

   ////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////
   function automatic ex_mem_t model_ex_mem(input instr_u w, input logic [31:0] rs_v,
                                            input logic [31:0] rt_v, output logic legal);
      logic [31:0] sx;
      logic [31:0] zx;
      logic        write;
      ex_mem_t     e;
      sx = {{16{w.ifmt.imm[15]}}, w.ifmt.imm};
      zx = {16'h0000, w.ifmt.imm};
      e = '0;
      e.valid = 1'b1;
      e.store_data = rt_v;
      legal = 1'b1;
      write = 1'b1;
      if (w.rfmt.opcode == OP_RTYPE)
      begin
         e.dest = w.rfmt.rd;
         case (w.rfmt.funct)
            FN_SLL:  e.result = rt_v << w.rfmt.shamt;
            FN_SRL:  e.result = rt_v >> w.rfmt.shamt;
            FN_SRA:  e.result = $signed(rt_v) >>> w.rfmt.shamt;
            FN_SLLV: e.result = rt_v << rs_v[4:0];
            FN_SRLV: e.result = rt_v >> rs_v[4:0];
            FN_SRAV: e.result = $signed(rt_v) >>> rs_v[4:0];
            FN_ADDU: e.result = rs_v + rt_v;
            FN_SUBU: e.result = rs_v - rt_v;
            FN_AND:  e.result = rs_v & rt_v;
            FN_OR:   e.result = rs_v | rt_v;
            FN_XOR:  e.result = rs_v ^ rt_v;
            FN_NOR:  e.result = ~(rs_v | rt_v);
            FN_SLT:  e.result = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
            FN_JR:
            begin
               e.result = rs_v;                  // Jump target
               write = 1'b0;
            end
            default: legal = 1'b0;
         endcase
      end
      else
      begin
         e.dest = w.ifmt.rt;
         case (w.ifmt.opcode)
            OP_ADDI, OP_ADDIU: e.result = rs_v + sx;
            OP_SLTI: e.result = ($signed(rs_v) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_ANDI: e.result = rs_v & zx;
            OP_ORI:  e.result = rs_v | zx;
            OP_XORI: e.result = rs_v ^ zx;
            OP_LUI:  e.result = {w.ifmt.imm, 16'h0000};
            OP_LW:   e.result = rs_v + sx;
            OP_SW:
            begin
               e.result = rs_v + sx;
               write = 1'b0;
            end
            default: legal = 1'b0;
         endcase
      end
      e.reg_write = legal && write && (e.dest != 5'd0);
      return e;
   endfunction

   ////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////
   task automatic field_match(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp, inout logic ok);
      if (got !== exp)
      begin
         $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
         ok = 1'b0;
      end
   endtask

   task automatic check_valid(input ex_mem_t got, input logic exp_valid,
                              input logic exp_write, output logic ok);
      ok = 1'b1;
      field_match("o_ex_mem.valid", got.valid, exp_valid, ok);
      field_match("o_ex_mem.reg_write", got.reg_write, exp_write, ok);
   endtask

   task automatic check_ex_mem(input ex_mem_t got, input ex_mem_t exp, output logic ok);
      check_valid(got, exp.valid, exp.reg_write, ok);
      field_match("o_ex_mem.dest", got.dest, exp.dest, ok);
      field_match("o_ex_mem.result", got.result, exp.result, ok);
      field_match("o_ex_mem.store_data", got.store_data, exp.store_data, ok);
   endtask

   task automatic report(input string name, input logic ok);
      if (ok)
         pass_count++;
      else
         fail_count++;
      $display("%-8s %s", name, ok ? "ok" : "FAILED");
   endtask

   // Each expected record is compared at its own negedge
   always @(negedge clock)
   begin
      exp_t e;
      logic ok;
      neg_count = neg_count + 1;
      if (exp_q.size() > 0 && exp_q[0].due == neg_count)
      begin
         e = exp_q.pop_front();
         if (e.full)
            check_ex_mem(ex_mem, e.rec, ok);
         else
            check_valid(ex_mem, e.rec.valid, e.rec.reg_write, ok);
         report(names[e.row], ok);
      end
   end

   initial
   begin
      wait (table_ready);
      repeat (rows.size() * 2 + 20) @(posedge clock);
      $display("Timeout: pipeline did not drain within %0d cycles", rows.size() * 2 + 20);
      $display("TEST FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////
   initial
   begin
      exp_t e;
      logic legal;
      logic ok;
      rst_n  = 1'b0;
      valid  = 1'b0;
      instr  = '0;
      rs_val = '0;
      rt_val = '0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clock);
      rst_n <= 1'b1;
      @(negedge clock);
      check_valid(ex_mem, 1'b0, 1'b0, ok);       // Cleared by reset
      report("reset", ok);

      for (int r = 0; r < rows.size(); r++)
      begin
         @(posedge clock);
         valid  <= !rows[r].bubble;
         instr  <= rows[r].word;
         rs_val <= rows[r].rs_val;
         rt_val <= rows[r].rt_val;
         e.rec  = model_ex_mem(rows[r].word, rows[r].rs_val, rows[r].rt_val, legal);
         e.full = legal && !rows[r].bubble;
         if (rows[r].bubble)
         begin
            e.rec.valid     = 1'b0;
            e.rec.reg_write = 1'b0;
         end
         e.row = r;
         e.due = neg_count + 3;                  // Third falling edge, after both stages
         exp_q.push_back(e);
      end
      @(posedge clock);
      valid <= 1'b0;
      wait (exp_q.size() == 0);
      @(posedge clock);

      $display("Tests: %0d run, %0d passed, %0d failed",
               pass_count + fail_count, pass_count, fail_count);
      if (fail_count == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire
